//--- bench/eth_rx_tb_model.svh
`ifndef ETH_RX_TB_MODEL_SVH
`define ETH_RX_TB_MODEL_SVH

// Frame under construction, destination first and FCS last
byte_t frame[$];

// Reflected CRC-32 as used by software, result already inverted
function automatic logic [31:0] ref_crc32(input byte_t data[$]);
   logic [31:0] c;
   c = 32'hffff_ffff;
   foreach (data[i]) begin
      c = c ^ {24'h0, data[i]};
      for (int b = 0; b < 8; b++) begin
         c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
      end
   end
   return ~c;
endfunction

// Destination, random payload, then FCS least significant byte first
task automatic build_frame(input mac_addr_t dest, input int payload_len);
   logic [31:0] fcs;
   frame.delete();
   for (int i = 5; i >= 0; i--) begin
      frame.push_back(dest[8*i +: 8]);
   end
   repeat (payload_len) begin
      frame.push_back(byte_t'($urandom));
   end
   fcs = ref_crc32(frame);
   for (int i = 0; i < 4; i++) begin
      frame.push_back(fcs[8*i +: 8]);
   end
endtask

task automatic drive_nibble(input logic [3:0] nib);
   @(negedge MRxClk);
   mrxdv = 1'b1;
   mrxd  = nib;
endtask

// Preamble, SFD, bytes low nibble first, then an idle gap
task automatic send_frame(input byte_t data[$]);
   int gap;
   gap = 12 + $urandom_range(0, 8);
   repeat (15) begin
      drive_nibble(4'h5);
   end
   drive_nibble(4'hd);
   foreach (data[i]) begin
      drive_nibble(data[i][3:0]);
      drive_nibble(data[i][7:4]);
   end
   @(negedge MRxClk);
   mrxdv = 1'b0;
   mrxd  = 4'h0;
   repeat (gap) @(negedge MRxClk);
endtask

// Little-endian packing of frame bytes into buffer words
function automatic word_t packed_word(input byte_t data[$], input int w);
   word_t v;
   v = '0;
   for (int l = 0; l < 4; l++) begin
      if (4*w + l < data.size()) v[8*l +: 8] = data[4*w + l];
   end
   return v;
endfunction

function automatic word_t lane_mask(input int len, input int w);
   word_t m;
   m = '0;
   for (int l = 0; l < 4; l++) begin
      if (4*w + l < len) m[8*l +: 8] = 8'hff;  // Lanes past the end stay unchecked
   end
   return m;
endfunction

`endif

//--- bench/eth_rx_tb.sv
`default_nettype none
`include "eth_rx_cfg.svh"

module eth_rx_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import eth_rx_pkg::*;

   localparam int max_cycles = 40 * 400;  // 40 frames, 400 cycles each at most
   localparam mac_addr_t own_addr = `ETH_MAC_ADDR;

   logic      MRxClk = 1'b0;
   logic      ETH_PHY_RESETN;
   logic [3:0] mrxd;
   logic      mrxdv;
   logic      rcv_ack;
   buf_addr_t rd_addr;
   logic      rx_data_rcvd;
   byte_cnt_t rx_size;
   logic      rx_crc_ok;
   word_t     rd_data;
   logic      phy_clk_det;
   logic      phy_dv_det;
   int        cycles = 0;
   byte_t     held[$];     // Frame kept while a second one is ignored
   mac_addr_t other_addr;

   `include "eth_rx_tb_model.svh"

   eth_rx_top u_dut (
      .MRxClk            (MRxClk),
      .ETH_PHY_RESETN    (ETH_PHY_RESETN),
      .mrxd_i            (mrxd),
      .mrxdv_i           (mrxdv),
      .rcv_ack_i         (rcv_ack),
      .rd_addr_i         (rd_addr),
      .rx_data_rcvd_o    (rx_data_rcvd),
      .rx_size_o         (rx_size),
      .rx_crc_ok_o       (rx_crc_ok),
      .rd_data_o         (rd_data),
      .phy_clk_detected_o(phy_clk_det),
      .phy_dv_detected_o (phy_dv_det)
   );

   initial begin
      forever #5 MRxClk = ~MRxClk;
   end

   always @(posedge MRxClk) begin
      cycles++;
      if (cycles >= max_cycles) begin
         $display("timeout: the frame received level never arrived");
         $display("*** FAILED ***");
         $fatal(1);
      end
   end

   task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("mismatch %s: expected %h actual %h", name, exp, act);
         $display("*** FAILED ***");
         $fatal(1);
      end
   endtask

   // Read port has one cycle of latency, called on a falling edge
   task automatic check_buffer(input string name, input byte_t data[$]);
      int words;
      words = (data.size() + 3) / 4;
      for (int w = 0; w < words; w++) begin
         rd_addr = buf_addr_t'(w);
         @(negedge MRxClk);
         compare($sformatf("%s word %0d", name, w), packed_word(data, w),
                 rd_data & lane_mask(data.size(), w));
      end
   endtask

   task automatic check_received(input string name, input byte_t data[$], input logic crc_exp);
      while (!rx_data_rcvd) @(negedge MRxClk);
      compare({name, " size"}, data.size(), rx_size);
      compare({name, " crc"}, crc_exp, rx_crc_ok);
      check_buffer(name, data);
   endtask

   task automatic acknowledge();
      rcv_ack = 1'b1;
      @(negedge MRxClk);
      rcv_ack = 1'b0;
      compare("ack clears level", 0, rx_data_rcvd);
   endtask

   initial begin
      void'($urandom(8));
      ETH_PHY_RESETN = 1'b0;
      mrxd           = 4'h0;
      mrxdv          = 1'b0;
      rcv_ack        = 1'b0;
      rd_addr        = '0;
      repeat (8) @(negedge MRxClk);
      ETH_PHY_RESETN = 1'b1;
      compare("reset rcvd", 0, rx_data_rcvd);
      compare("reset dv", 0, phy_dv_det);
      repeat (4) @(negedge MRxClk);
      compare("phy clk seen", 1, phy_clk_det);

      build_frame(own_addr, $urandom_range(46, 60));
      send_frame(frame);
      check_received("own", frame, 1'b1);
      compare("dv seen", 1, phy_dv_det);
      acknowledge();

      build_frame('1, $urandom_range(46, 60));  // Broadcast
      send_frame(frame);
      check_received("broadcast", frame, 1'b1);
      acknowledge();

      do begin
         other_addr = mac_addr_t'({$urandom, $urandom});
      end while ((other_addr == own_addr) || (other_addr == '1));
      build_frame(other_addr, $urandom_range(46, 60));
      send_frame(frame);
      compare("other dropped", 0, rx_data_rcvd);
      build_frame(own_addr, $urandom_range(46, 60));
      send_frame(frame);
      check_received("after drop", frame, 1'b1);
      acknowledge();

      build_frame(own_addr, $urandom_range(46, 60));
      frame[20] = ~frame[20];  // Corrupt payload after FCS
      send_frame(frame);
      check_received("bad crc", frame, 1'b0);
      acknowledge();

      // Second frame arrives while the first is still unacknowledged
      build_frame(own_addr, $urandom_range(46, 60));
      held = frame;
      send_frame(frame);
      check_received("held", held, 1'b1);
      do begin
         build_frame('1, $urandom_range(46, 60));  // Broadcast, differs in word 0 and size
      end while (frame.size() == held.size());
      send_frame(frame);
      compare("hold level", 1, rx_data_rcvd);
      compare("hold size", held.size(), rx_size);
      rd_addr = '0;
      @(negedge MRxClk);
      compare("hold word 0", packed_word(held, 0), rd_data);
      acknowledge();
      build_frame(own_addr, $urandom_range(46, 60));
      send_frame(frame);
      check_received("after ack", frame, 1'b1);
      acknowledge();

      repeat (20) begin
         build_frame(own_addr, $urandom_range(46, 60));
         send_frame(frame);
         check_received("random", frame, 1'b1);
         acknowledge();
      end
      compare("dv sticky", 1, phy_dv_det);

      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
+incdir+src
+incdir+bench
src/eth_rx_pkg.sv
src/eth_rx_if.sv
src/eth_mii_rx_deframer.sv
src/eth_rx_ctrl.sv
src/eth_rx_crc32.sv
src/eth_rx_buf_writer.sv
src/eth_rx_buffer.sv
src/eth_rx_top.sv
bench/eth_rx_tb.sv

//--- src/eth_mii_rx_deframer.sv
`default_nettype none
`include "eth_rx_cfg.svh"

module eth_mii_rx_deframer (
   input wire logic       MRxClk,
   input wire logic       ETH_PHY_RESETN,
   input wire logic [3:0] mrxd_i,
   input wire logic       mrxdv_i,
   eth_rx_byte_if.source  byte_o
);

   typedef enum logic [1:0] {
      HUNT,      // Looking for 5 then SFD nibble
      LOW_NIB,
      HIGH_NIB
   } dfr_state_e;

   dfr_state_e state;
   logic       saw_5;    // Last nibble was a preamble 5
   logic [3:0] low_nib;

   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         state           <= HUNT;
         saw_5           <= 1'b0;
         byte_o.sof      <= 1'b0;
         byte_o.eof      <= 1'b0;
         byte_o.byte_vld <= 1'b0;
      end else begin
         byte_o.sof      <= 1'b0;
         byte_o.eof      <= 1'b0;
         byte_o.byte_vld <= 1'b0;
         saw_5           <= mrxdv_i && (mrxd_i == 4'h5);

         if (state == HUNT) begin
            if (mrxdv_i && saw_5 && (mrxd_i == `ETH_SFD_NIBBLE)) begin
               state      <= LOW_NIB;
               byte_o.sof <= 1'b1;
            end
         end else if (!mrxdv_i) begin
            // End of frame, an odd nibble is simply lost
            state      <= HUNT;
            byte_o.eof <= 1'b1;
         end else if (state == LOW_NIB) begin
            state <= HIGH_NIB;
         end else begin
            state           <= LOW_NIB;
            byte_o.byte_vld <= 1'b1;
         end
      end
   end

   // Nibble pairing, low nibble arrives first
   always_ff @(posedge MRxClk) begin
      if (state == LOW_NIB) begin
         low_nib <= mrxd_i;
      end
      if (state == HIGH_NIB) begin
         byte_o.data <= {mrxd_i, low_nib};
      end
   end

endmodule

`default_nettype wire

//--- src/eth_rx_buf_writer.sv
`default_nettype none

module eth_rx_buf_writer (
   input  wire logic             MRxClk,
   input  wire logic             ETH_PHY_RESETN,
   input  wire logic             restart_i,
   input  wire logic             capture_i,
   eth_rx_byte_if.sink           byte_i,
   output eth_rx_pkg::byte_cnt_t byte_count_o,
   eth_rxbuf_wr_if.writer        wr_o
);
   import eth_rx_pkg::*;

   byte_cnt_t byte_addr;   // Next byte position in the buffer
   logic      byte_wr;

   assign byte_wr      = capture_i && byte_i.byte_vld;
   assign byte_count_o = byte_addr;

   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         byte_addr <= '0;
         wr_o.en   <= 1'b0;
      end else begin
         wr_o.en <= byte_wr;
         if (restart_i) begin
            byte_addr <= '0;
         end else if (byte_wr) begin
            byte_addr <= byte_addr + 1'b1;
         end
      end
   end

   // Lane picked by the two low address bits
   always_ff @(posedge MRxClk) begin
      if (byte_wr) begin
         wr_o.addr  <= buf_addr_t'(byte_addr >> 2);
         wr_o.wdata <= word_t'(byte_i.data) << (8 * byte_addr[1:0]);
         wr_o.wstrb <= wstrb_t'(1) << byte_addr[1:0];
      end
   end

endmodule

`default_nettype wire

//--- src/eth_rx_buffer.sv
`default_nettype none

module eth_rx_buffer (
   input  wire logic                  MRxClk,
   eth_rxbuf_wr_if.buffer             wr_i,
   input  wire eth_rx_pkg::buf_addr_t rd_addr_i,
   output eth_rx_pkg::word_t          rd_data_o
);
   import eth_rx_pkg::*;

   localparam int depth = 2 ** $bits(buf_addr_t);
   localparam int lanes = $bits(wstrb_t);

   word_t mem [depth];

   // Byte-lane writes from the receive side
   always_ff @(posedge MRxClk) begin
      if (wr_i.en) begin
         for (int i = 0; i < lanes; i++) begin
            if (wr_i.wstrb[i]) begin
               mem[wr_i.addr][8*i +: 8] <= wr_i.wdata[8*i +: 8];
            end
         end
      end
   end

   // Host read, one cycle latency
   always_ff @(posedge MRxClk) begin
      rd_data_o <= mem[rd_addr_i];
   end

endmodule

`default_nettype wire

//--- src/eth_rx_cfg.svh
`ifndef ETH_RX_CFG_SVH
`define ETH_RX_CFG_SVH

// Station address, top byte goes out first on the wire
`define ETH_MAC_ADDR 48'h02_12_34_56_78_9a

// Word address width of the receive buffer (512 words of 32 bits)
`define ETH_RX_BUF_ADDR_W 9

// Second nibble of the start-of-frame delimiter
`define ETH_SFD_NIBBLE 4'hd

// Remainder left in the CRC register by a good frame
`define ETH_CRC_RESIDUE 32'hc704dd7b

`endif

//--- src/eth_rx_crc32.sv
`default_nettype none
`include "eth_rx_cfg.svh"

module eth_rx_crc32 (
   input  wire logic   MRxClk,
   input  wire logic   ETH_PHY_RESETN,
   input  wire logic   restart_i,
   input  wire logic   capture_i,
   eth_rx_byte_if.sink byte_i,
   output logic        crc_ok_o
);
   import eth_rx_pkg::*;

   localparam logic [31:0] crc_poly = 32'h04c11db7;

   logic [31:0] crc;

   // Bits enter LSB first while the register is kept MSB first
   function automatic logic [31:0] crc_byte(input logic [31:0] c, input byte_t d);
      logic [31:0] r;
      logic        fb;
      r = c;
      for (int i = 0; i < 8; i++) begin
         fb = r[31] ^ d[i];
         r  = {r[30:0], 1'b0} ^ (fb ? crc_poly : 32'h0);
      end
      return r;
   endfunction

   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         crc <= '1;
      end else if (restart_i) begin
         crc <= '1;
      end else if (capture_i && byte_i.byte_vld) begin
         crc <= crc_byte(crc, byte_i.data);
      end
   end

   // Data plus FCS leaves the fixed residue
   assign crc_ok_o = (crc == `ETH_CRC_RESIDUE);

endmodule

`default_nettype wire

//--- src/eth_rx_ctrl.sv
`default_nettype none
`include "eth_rx_cfg.svh"

module eth_rx_ctrl (
   input  wire logic                  MRxClk,
   input  wire logic                  ETH_PHY_RESETN,
   input  wire logic                  mrxdv_i,
   eth_rx_byte_if.sink                byte_i,
   input  wire eth_rx_pkg::byte_cnt_t byte_count_i,
   input  wire logic                  crc_ok_i,
   input  wire logic                  rcv_ack_i,
   output logic                       capture_o,
   output logic                       restart_o,
   output logic                       data_rcvd_o,
   output eth_rx_pkg::byte_cnt_t      rcv_size_o,
   output logic                       crc_ok_o,
   output logic                       phy_clk_detected_o,
   output logic                       phy_dv_detected_o
);
   import eth_rx_pkg::*;

   localparam mac_addr_t station_addr = `ETH_MAC_ADDR;
   localparam mac_addr_t bcast_addr   = '1;

   rx_state_e  state;
   logic [2:0] dest_idx;     // Destination byte index 0..5
   logic       own_match;
   logic       bcast_match;
   logic       own_nxt;
   logic       bcast_nxt;
   byte_t      own_byte;
   byte_t      bcast_byte;
   logic [1:0] rx_rst;       // Reset stretcher

   // First destination byte on the wire is the top byte of the address
   always_comb begin
      own_byte   = station_addr[8*(5 - dest_idx) +: 8];
      bcast_byte = bcast_addr[8*(5 - dest_idx) +: 8];
      own_nxt    = own_match && (byte_i.data == own_byte);
      bcast_nxt  = bcast_match && (byte_i.data == bcast_byte);
   end

   assign capture_o   = (state == DEST) || (state == PAYLOAD);
   assign restart_o   = (state == IDLE) && byte_i.sof;
   assign data_rcvd_o = (state == HOLD);

   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         state       <= IDLE;
         dest_idx    <= '0;
         own_match   <= 1'b0;
         bcast_match <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (byte_i.sof) begin
                  state       <= DEST;
                  dest_idx    <= '0;
                  own_match   <= 1'b1;
                  bcast_match <= 1'b1;
               end
            end
            DEST: begin
               if (byte_i.eof) begin
                  state <= IDLE;    // Runt, shorter than an address
               end else if (byte_i.byte_vld) begin
                  own_match   <= own_nxt;
                  bcast_match <= bcast_nxt;
                  dest_idx    <= dest_idx + 3'd1;
                  if (!(own_nxt || bcast_nxt)) begin
                     state <= SKIP;
                  end else if (dest_idx == 3'd5) begin
                     state <= PAYLOAD;
                  end
               end
            end
            PAYLOAD: if (byte_i.eof) state <= HOLD;
            SKIP:    if (byte_i.eof) state <= IDLE;
            HOLD:    if (rcv_ack_i) state <= IDLE;   // Frames ignored meanwhile
            default: state <= IDLE;
         endcase
      end
   end

   // Size and CRC result of the delivered frame
   always_ff @(posedge MRxClk) begin
      if ((state == PAYLOAD) && byte_i.eof) begin
         rcv_size_o <= byte_count_i;
         crc_ok_o   <= crc_ok_i;
      end
   end

   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         rx_rst <= 2'b11;
      end else begin
         rx_rst <= {rx_rst[0], 1'b0};
      end
   end

   // PHY status flags, held clear while the stretcher runs
   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         phy_clk_detected_o <= 1'b0;
         phy_dv_detected_o  <= 1'b0;
      end else if (rx_rst[1]) begin
         phy_clk_detected_o <= 1'b0;
         phy_dv_detected_o  <= 1'b0;
      end else begin
         phy_clk_detected_o <= 1'b1;
         if (mrxdv_i) begin
            phy_dv_detected_o <= 1'b1;  // Sticky
         end
      end
   end

endmodule

`default_nettype wire

//--- src/eth_rx_if.sv
`default_nettype none

// Byte stream out of the MII deframer
interface eth_rx_byte_if;
   import eth_rx_pkg::*;

   logic  sof;       // Pulse in the cycle after the SFD
   logic  eof;       // Pulse in the cycle after MRxDv drops
   logic  byte_vld;  // One cycle per assembled byte
   byte_t data;

   modport source (
      output sof,
      output eof,
      output byte_vld,
      output data
   );

   modport sink (
      input sof,
      input eof,
      input byte_vld,
      input data
   );
endinterface

// Byte-lane write port of the receive buffer
interface eth_rxbuf_wr_if;
   import eth_rx_pkg::*;

   logic      en;
   wstrb_t    wstrb;
   buf_addr_t addr;
   word_t     wdata;

   modport writer (output en, output wstrb, output addr, output wdata);
   modport buffer (input en, input wstrb, input addr, input wdata);
endinterface

`default_nettype wire

//--- src/eth_rx_pkg.sv
`default_nettype none
`include "eth_rx_cfg.svh"

package eth_rx_pkg;

   // One frame byte
   typedef logic [7:0] byte_t;

   // One buffer word and its byte lanes
   typedef logic [31:0] word_t;
   typedef logic [3:0]  wstrb_t;

   // Word address into the receive buffer
   typedef logic [`ETH_RX_BUF_ADDR_W-1:0] buf_addr_t;

   // Byte address or frame size, two bits wider than the word address
   typedef logic [`ETH_RX_BUF_ADDR_W+1:0] byte_cnt_t;

   typedef logic [47:0] mac_addr_t;

   // Receive control states
   typedef enum logic [2:0] {
      IDLE,     // Waiting for a delimiter
      DEST,     // Checking destination address
      PAYLOAD,  // Frame accepted
      SKIP,     // Frame dropped until its end
      HOLD      // Waiting for host acknowledge
   } rx_state_e;

endpackage

`default_nettype wire

//--- src/eth_rx_top.sv
`default_nettype none

module eth_rx_top (
   input  wire logic                  MRxClk,
   input  wire logic                  ETH_PHY_RESETN,
   input  wire logic [3:0]            mrxd_i,
   input  wire logic                  mrxdv_i,
   input  wire logic                  rcv_ack_i,
   input  wire eth_rx_pkg::buf_addr_t rd_addr_i,
   output logic                       rx_data_rcvd_o,
   output eth_rx_pkg::byte_cnt_t      rx_size_o,
   output logic                       rx_crc_ok_o,
   output eth_rx_pkg::word_t          rd_data_o,
   output logic                       phy_clk_detected_o,
   output logic                       phy_dv_detected_o
);
   import eth_rx_pkg::*;

   logic      capture;
   logic      restart;
   logic      crc_ok;
   byte_cnt_t byte_count;

   eth_rx_byte_if  byte_if ();
   eth_rxbuf_wr_if wr_if ();

   eth_mii_rx_deframer u_deframer (
      .MRxClk        (MRxClk),
      .ETH_PHY_RESETN(ETH_PHY_RESETN),
      .mrxd_i        (mrxd_i),
      .mrxdv_i       (mrxdv_i),
      .byte_o        (byte_if.source)
   );

   eth_rx_ctrl u_ctrl (
      .MRxClk            (MRxClk),
      .ETH_PHY_RESETN    (ETH_PHY_RESETN),
      .mrxdv_i           (mrxdv_i),
      .byte_i            (byte_if.sink),
      .byte_count_i      (byte_count),
      .crc_ok_i          (crc_ok),
      .rcv_ack_i         (rcv_ack_i),
      .capture_o         (capture),
      .restart_o         (restart),
      .data_rcvd_o       (rx_data_rcvd_o),
      .rcv_size_o        (rx_size_o),
      .crc_ok_o          (rx_crc_ok_o),
      .phy_clk_detected_o(phy_clk_detected_o),
      .phy_dv_detected_o (phy_dv_detected_o)
   );

   eth_rx_crc32 u_crc (
      .MRxClk        (MRxClk),
      .ETH_PHY_RESETN(ETH_PHY_RESETN),
      .restart_i     (restart),
      .capture_i     (capture),
      .byte_i        (byte_if.sink),
      .crc_ok_o      (crc_ok)
   );

   eth_rx_buf_writer u_writer (
      .MRxClk        (MRxClk),
      .ETH_PHY_RESETN(ETH_PHY_RESETN),
      .restart_i     (restart),
      .capture_i     (capture),
      .byte_i        (byte_if.sink),
      .byte_count_o  (byte_count),
      .wr_o          (wr_if.writer)
   );

   eth_rx_buffer u_buffer (
      .MRxClk   (MRxClk),
      .wr_i     (wr_if.buffer),
      .rd_addr_i(rd_addr_i),
      .rd_data_o(rd_data_o)
   );

endmodule

`default_nettype wire
